/* Makefile */
# Verilator build and run for the PS/2 keyboard testbench

VERILATOR ?= verilator
TOP       ?= keyboardTb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# pass or fail is decided from the log
run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* rtl/keyDecoder.sv */
`timescale 1ns/10ps

module keyDecoder (
    input  logic [keyPkg::keyWidth-1:0]    key,
    input  logic                           keyPressed,
    input  logic                           newKey,
    output logic                           left,
    output logic                           right,
    output logic                           backspace,
    output logic [keyPkg::symbolWidth-1:0] symbol
);

    import keyPkg::*;

    logic                   pressEvent;
    logic [symbolWidth-1:0] lookup;

    assign pressEvent = newKey && keyPressed;

    assign left = pressEvent && (key == keyLeft);
    assign right = pressEvent && (key == keyRight);
    assign backspace = pressEvent && (key == keyBackspace);

    // scan code set 2, main block then keypad
    always_comb begin
        case (key)
            16'h0016: lookup = symbolWidth'("1");
            16'h001E: lookup = symbolWidth'("2");
            16'h0026: lookup = symbolWidth'("3");
            16'h0025: lookup = symbolWidth'("4");
            16'h002E: lookup = symbolWidth'("5");
            16'h0036: lookup = symbolWidth'("6");
            16'h003D: lookup = symbolWidth'("7");
            16'h003E: lookup = symbolWidth'("8");
            16'h0046: lookup = symbolWidth'("9");
            16'h0045: lookup = symbolWidth'("0");
            16'h004E: lookup = symbolWidth'("-");
            16'h0015: lookup = symbolWidth'("q");
            16'h001D: lookup = symbolWidth'("w");
            16'h0024: lookup = symbolWidth'("e");
            16'h002D: lookup = symbolWidth'("r");
            16'h002C: lookup = symbolWidth'("t");
            16'h0035: lookup = symbolWidth'("y");
            16'h003C: lookup = symbolWidth'("u");
            16'h0043: lookup = symbolWidth'("i");
            16'h0044: lookup = symbolWidth'("o");
            16'h004D: lookup = symbolWidth'("p");
            16'h0054: lookup = symbolWidth'("[");
            16'h005B: lookup = symbolWidth'("]");
            16'h001C: lookup = symbolWidth'("a");
            16'h001B: lookup = symbolWidth'("s");
            16'h0023: lookup = symbolWidth'("d");
            16'h002B: lookup = symbolWidth'("f");
            16'h0034: lookup = symbolWidth'("g");
            16'h0033: lookup = symbolWidth'("h");
            16'h003B: lookup = symbolWidth'("j");
            16'h0042: lookup = symbolWidth'("k");
            16'h004B: lookup = symbolWidth'("l");
            16'h001A: lookup = symbolWidth'("z");
            16'h0022: lookup = symbolWidth'("x");
            16'h0021: lookup = symbolWidth'("c");
            16'h002A: lookup = symbolWidth'("v");
            16'h0032: lookup = symbolWidth'("b");
            16'h0031: lookup = symbolWidth'("n");
            16'h003A: lookup = symbolWidth'("m");
            16'h0049: lookup = symbolWidth'(".");
            16'h004A: lookup = symbolWidth'("/");
            // keypad; its slash is the extended code
            16'hE04A: lookup = symbolWidth'("/");
            16'h007C: lookup = symbolWidth'("*");
            16'h007B: lookup = symbolWidth'("-");
            16'h0079: lookup = symbolWidth'("+");
            16'h006C: lookup = symbolWidth'("7");
            16'h0075: lookup = symbolWidth'("8");
            16'h007D: lookup = symbolWidth'("9");
            16'h006B: lookup = symbolWidth'("4");
            16'h0073: lookup = symbolWidth'("5");
            16'h0074: lookup = symbolWidth'("6");
            16'h0069: lookup = symbolWidth'("1");
            16'h0072: lookup = symbolWidth'("2");
            16'h007A: lookup = symbolWidth'("3");
            16'h0070: lookup = symbolWidth'("0");
            16'h0071: lookup = symbolWidth'(".");
            default:  lookup = '0;
        endcase
    end

    // releases and idle cycles give no symbol
    assign symbol = pressEvent ? lookup : '0;

endmodule

/* rtl/keyPkg.sv */
package keyPkg;

    // high byte is E0 for extended keys, 00 otherwise
    localparam int keyWidth = 16;

    // unshifted 7-bit ascii
    localparam int symbolWidth = 7;

    // keys that come out as strobes instead of symbols
    localparam logic [keyWidth-1:0] keyLeft = 16'hE06B;
    localparam logic [keyWidth-1:0] keyRight = 16'hE074;
    localparam logic [keyWidth-1:0] keyBackspace = 16'h0066;

endpackage

/* rtl/keyboard.sv */
`timescale 1ns/10ps

module keyboard (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           ps2Clk,
    input  logic                           ps2Dat,
    output logic                           left,
    output logic                           right,
    output logic                           backspace,
    output logic                           frameError,
    output logic [keyPkg::symbolWidth-1:0] symbol
);

    import keyPkg::*;

    logic [7:0]          rxByte;
    logic                byteValid;
    logic [keyWidth-1:0] key;
    logic                keyPressed;
    logic                newKey;

    ps2FrameRx frameRx (
        .clk        (clk),
        .arstN      (arstN),
        .ps2Clk     (ps2Clk),
        .ps2Dat     (ps2Dat),
        .rxByte     (rxByte),
        .byteValid  (byteValid),
        .frameError (frameError)
    );

    // frameError also drops any pending prefix
    scanCodeAssembler assembler (
        .clk        (clk),
        .arstN      (arstN),
        .rxByte     (rxByte),
        .byteValid  (byteValid),
        .frameError (frameError),
        .key        (key),
        .keyPressed (keyPressed),
        .newKey     (newKey)
    );

    keyDecoder decoder (
        .key        (key),
        .keyPressed (keyPressed),
        .newKey     (newKey),
        .left       (left),
        .right      (right),
        .backspace  (backspace),
        .symbol     (symbol)
    );

endmodule

/* rtl/ps2FrameRx.sv */
`timescale 1ns/10ps

module ps2FrameRx (
    input  logic       clk,
    input  logic       arstN,
    input  logic       ps2Clk,
    input  logic       ps2Dat,
    output logic [7:0] rxByte,
    output logic       byteValid,
    output logic       frameError
);

    import ps2Pkg::*;

    logic [1:0]               clkSync;
    logic [1:0]               datSync;
    logic [filterDepth-1:0]   clkHist;
    logic                     cleanClk;
    logic                     fallEdge;
    logic                     stopEdge;
    logic [bitCountWidth-1:0] bitCnt;
    logic [frameBits-2:0]     shiftReg;
    logic [frameBits-1:0]     nextFrame;
    logic                     frameGood;
    logic [watchdogWidth-1:0] wdCnt;
    logic                     wdExpired;

    // both lines idle high, so the synchronisers reset to 1
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            clkSync <= 2'b11;
            datSync <= 2'b11;
        end else begin
            clkSync <= {clkSync[0], ps2Clk};
            datSync <= {datSync[0], ps2Dat};
        end
    end

    // level only changes once the whole history agrees
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            clkHist <= '1;
            cleanClk <= 1'b1;
        end else begin
            clkHist <= {clkHist[filterDepth-2:0], clkSync[1]};
            if (&clkHist) begin
                cleanClk <= 1'b1;
            end else if (~|clkHist) begin
                cleanClk <= 1'b0;
            end
        end
    end

    assign fallEdge = cleanClk && (clkHist == '0);
    assign stopEdge = fallEdge && (bitCnt == bitCountWidth'(frameBits - 1));

    // new bit enters at the top, so bit 0 ends up holding the start bit
    assign nextFrame = {datSync[1], shiftReg};
    assign frameGood = !nextFrame[startPos]
                       && (^nextFrame[parityPos:dataLsb])
                       && nextFrame[stopPos];

    assign wdExpired = (wdCnt == watchdogWidth'(watchdogCycles - 1));

    always_ff @(posedge clk) begin
        if (fallEdge) begin
            shiftReg <= nextFrame[frameBits-1:1];
        end
    end

    // watchdog only runs while a frame is partly received
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bitCnt <= '0;
            wdCnt <= '0;
        end else if (fallEdge) begin
            wdCnt <= '0;
            if (stopEdge) begin
                bitCnt <= '0;
            end else begin
                bitCnt <= bitCnt + 1'b1;
            end
        end else if (bitCnt != '0) begin
            if (wdExpired) begin
                bitCnt <= '0;
                wdCnt <= '0;
            end else begin
                wdCnt <= wdCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            byteValid <= 1'b0;
            frameError <= 1'b0;
        end else begin
            byteValid <= stopEdge && frameGood;
            frameError <= stopEdge && !frameGood;
        end
    end

    always_ff @(posedge clk) begin
        if (stopEdge) begin
            rxByte <= nextFrame[dataMsb:dataLsb];
        end
    end

    validErrorExclusive: assert property (
        @(posedge clk) disable iff (!arstN) !(byteValid && frameError)
    );

    byteValidPulse: assert property (
        @(posedge clk) disable iff (!arstN) byteValid |=> !byteValid
    );

    frameErrorPulse: assert property (
        @(posedge clk) disable iff (!arstN) frameError |=> !frameError
    );

endmodule

/* rtl/ps2Pkg.sv */
package ps2Pkg;

    // one frame: start, eight data bits LSB first, odd parity, stop
    localparam int frameBits = 11;
    localparam int bitCountWidth = $clog2(frameBits);

    // bit positions inside a completed frame
    localparam int startPos = 0;
    localparam int dataLsb = 1;
    localparam int dataMsb = 8;
    localparam int parityPos = 9;
    localparam int stopPos = 10;

    // consecutive equal samples before a new ps2 clock level is taken
    localparam int filterDepth = 4;

    // system clocks of silence before a partial frame is dropped
    localparam int watchdogCycles = 4096;
    localparam int watchdogWidth = $clog2(watchdogCycles);

    // scan code prefixes
    localparam logic [7:0] extendPrefix = 8'hE0;
    localparam logic [7:0] breakPrefix = 8'hF0;

endpackage

/* rtl/scanCodeAssembler.sv */
`timescale 1ns/10ps

module scanCodeAssembler (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic [7:0]                  rxByte,
    input  logic                        byteValid,
    input  logic                        frameError,
    output logic [keyPkg::keyWidth-1:0] key,
    output logic                        keyPressed,
    output logic                        newKey
);

    import ps2Pkg::*;

    logic extended;
    logic released;
    logic isPrefix;
    logic codeByte;

    assign isPrefix = (rxByte == extendPrefix) || (rxByte == breakPrefix);
    assign codeByte = byteValid && !isPrefix;

    // prefix flags and the event strobe
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            extended <= 1'b0;
            released <= 1'b0;
            newKey <= 1'b0;
        end else begin
            newKey <= codeByte;
            if (frameError || codeByte) begin
                extended <= 1'b0;
                released <= 1'b0;
            end else if (byteValid && (rxByte == extendPrefix)) begin
                extended <= 1'b1;
            end else if (byteValid && (rxByte == breakPrefix)) begin
                released <= 1'b1;
            end
        end
    end

    // payload is only looked at while newKey is high
    always_ff @(posedge clk) begin
        if (codeByte) begin
            key <= {(extended ? extendPrefix : 8'h00), rxByte};
            keyPressed <= !released;
        end
    end

    // a key event needs at least one frame, so events can never be adjacent
    newKeyPulse: assert property (
        @(posedge clk) disable iff (!arstN) newKey |=> !newKey
    );

endmodule

/* tb.f */
rtl/ps2Pkg.sv
rtl/keyPkg.sv
rtl/ps2FrameRx.sv
rtl/scanCodeAssembler.sv
rtl/keyDecoder.sv
rtl/keyboard.sv
tests/keyboardTb.sv

/* tests/keyboardTb.sv */
`timescale 1ns/10ps

module keyboardTb;

    import keyPkg::*;
    import ps2Pkg::*;

    localparam int halfPeriod = 20;
    localparam int byteGap = 40;
    localparam int settleCycles = 100;
    localparam int eventTimeout = 2000;
    localparam int mappedCount = 56;
    localparam int keyCount = 67;
    localparam int randomStrokes = 80;

    logic                   clk;
    logic                   arstN;
    logic                   ps2Clk;
    logic                   ps2Dat;
    logic                   left;
    logic                   right;
    logic                   backspace;
    logic                   frameError;
    logic [symbolWidth-1:0] symbol;

    integer     seed;
    int         mismatches = 0;
    int         timeouts = 0;
    int         frameErrors = 0;
    int         expectedErrors = 0;
    logic [9:0] events[$];

    // first mappedCount entries line up with symbolChars, then specials, then unmapped keys
    logic [15:0] keyTable [keyCount] = '{
        16'h0016, 16'h001E, 16'h0026, 16'h0025, 16'h002E, 16'h0036, 16'h003D, 16'h003E,
        16'h0046, 16'h0045, 16'h004E,
        16'h0015, 16'h001D, 16'h0024, 16'h002D, 16'h002C, 16'h0035, 16'h003C, 16'h0043,
        16'h0044, 16'h004D, 16'h0054, 16'h005B,
        16'h001C, 16'h001B, 16'h0023, 16'h002B, 16'h0034, 16'h0033, 16'h003B, 16'h0042,
        16'h004B,
        16'h001A, 16'h0022, 16'h0021, 16'h002A, 16'h0032, 16'h0031, 16'h003A, 16'h004A,
        16'h0049,
        16'h007C, 16'h007B, 16'h0079, 16'h006C, 16'h0075, 16'h007D, 16'h006B, 16'h0073,
        16'h0074, 16'h0069, 16'h0072, 16'h007A, 16'h0070, 16'h0071, 16'hE04A,
        16'hE06B, 16'hE074, 16'h0066,
        16'h000D, 16'h005A, 16'h0076, 16'h0011, 16'h0058, 16'hE075, 16'hE072, 16'hE011
    };
    string symbolChars = "1234567890-qwertyuiop[]asdfghjklzxcvbnm/.*-+7894561230./";

    keyboard uut (
        .clk        (clk),
        .arstN      (arstN),
        .ps2Clk     (ps2Clk),
        .ps2Dat     (ps2Dat),
        .left       (left),
        .right      (right),
        .backspace  (backspace),
        .frameError (frameError),
        .symbol     (symbol)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // outputs only change after a rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (left || right || backspace || (symbol != '0)) begin
            events.push_back({left, right, backspace, symbol});
        end
        if (frameError) begin
            frameErrors++;
        end
    end

    // {left, right, backspace, symbol} for a press of this key
    function automatic logic [9:0] expectedEvent(input logic [15:0] code);
        logic [9:0] ev;
        byte        ch;
        ev = '0;
        if (code == 16'hE06B) begin
            ev[9] = 1'b1;
        end else if (code == 16'hE074) begin
            ev[8] = 1'b1;
        end else if (code == 16'h0066) begin
            ev[7] = 1'b1;
        end else begin
            for (int i = 0; i < mappedCount; i++) begin
                if (keyTable[i] == code) begin
                    ch = symbolChars[i];
                    ev[6:0] = ch[6:0];
                end
            end
        end
        return ev;
    endfunction

    task automatic waitCycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    // device side: data moves while ps2Clk is high, the host samples on its fall
    task automatic driveFrame(input logic [10:0] frame, input int nBits);
        for (int b = 0; b < nBits; b++) begin
            ps2Dat = frame[b];
            waitCycles(halfPeriod);
            ps2Clk = 1'b0;
            waitCycles(halfPeriod);
            ps2Clk = 1'b1;
        end
        ps2Dat = 1'b1;
        waitCycles(byteGap);
    endtask

    task automatic transmitByte(input logic [7:0] data, input logic badParity,
                                input logic badStop);
        logic        parity;
        logic [10:0] frame;
        parity = (~^data) ^ badParity;
        frame = {~badStop, parity, data, 1'b0};
        driveFrame(frame, 11);
    endtask

    task automatic typeKey(input logic [15:0] code, input logic press);
        if (code[15:8] == 8'hE0) begin
            transmitByte(8'hE0, 1'b0, 1'b0);
        end
        if (!press) begin
            transmitByte(8'hF0, 1'b0, 1'b0);
        end
        transmitByte(code[7:0], 1'b0, 1'b0);
    endtask

    task automatic checkOutcome(input logic [15:0] code, input logic [9:0] want);
        int waited;
        waited = 0;
        if (want != '0) begin
            while ((events.size() == 0) && (waited < eventTimeout)) begin
                @(negedge clk);
                waited++;
            end
            assert (events.size() != 0) else begin
                timeouts++;
                $display("No key event arrived for key %h within %0d cycles", code,
                         eventTimeout);
            end
        end
        waitCycles(settleCycles);
        if (want == '0) begin
            assert (events.size() == 0) else begin
                mismatches++;
                $display("Fail at %0t ns: key %h expected no event, got %0d, first %h",
                         $time, code, events.size(), events[0]);
            end
        end else if (events.size() != 0) begin
            assert ((events.size() == 1) && (events[0] == want)) else begin
                mismatches++;
                $display("Fail at %0t ns: key %h expected %h, got %h in %0d events",
                         $time, code, want, events[0], events.size());
            end
        end
        assert (frameErrors == expectedErrors) else begin
            mismatches++;
            $display("Fail at %0t ns: expected %0d frame errors, got %0d",
                     $time, expectedErrors, frameErrors);
        end
        events.delete();
    endtask

    task automatic strokeKey(input logic [15:0] code);
        typeKey(code, 1'b1);
        checkOutcome(code, expectedEvent(code));
        typeKey(code, 1'b0);
        checkOutcome(code, '0);
    endtask

    initial begin
        int idx;
        seed = 98334;
        arstN = 1'b0;
        ps2Clk = 1'b1;
        ps2Dat = 1'b1;
        for (int c = 0; c < 3; c++) begin
            @(negedge clk);
            assert (!left && !right && !backspace && !frameError && (symbol == '0)) else begin
                mismatches++;
                $display("Fail at %0t ns: outputs active during reset", $time);
            end
        end
        arstN = 1'b1;
        // idle after reset, nothing may come out
        checkOutcome(16'h0000, '0);

        // arrows, keypad slash, backspace
        strokeKey(16'hE06B);
        strokeKey(16'hE074);
        strokeKey(16'hE04A);
        strokeKey(16'h0066);

        for (int n = 0; n < randomStrokes; n++) begin
            idx = int'($unsigned($random(seed)) % keyCount);
            strokeKey(keyTable[idx]);
        end

        // bad parity after E0, the next 6B must be keypad 4 and not left
        transmitByte(8'hE0, 1'b0, 1'b0);
        transmitByte(8'h6B, 1'b1, 1'b0);
        expectedErrors++;
        checkOutcome(16'hE06B, '0);
        strokeKey(16'h006B);

        // bad stop bit after F0, the next 1C must still be a press
        transmitByte(8'hF0, 1'b0, 1'b0);
        transmitByte(8'h1C, 1'b0, 1'b1);
        expectedErrors++;
        checkOutcome(16'h001C, '0);
        strokeKey(16'h001C);

        // five bits then silence past the watchdog
        driveFrame({1'b1, 1'b0, 8'h1C, 1'b0}, 5);
        waitCycles(watchdogCycles + 1000);
        checkOutcome(16'h0000, '0);
        idx = int'($unsigned($random(seed)) % keyCount);
        strokeKey(keyTable[idx]);
        strokeKey(16'h0016);

        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if ((mismatches == 0) && (timeouts == 0)) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
